/* include/i2c_cu_settings.svh */
`ifndef I2C_CU_SETTINGS_SVH
`define I2C_CU_SETTINGS_SVH

// clock ticks spent on every bit of the bus.
`define I2C_PRESCALER 2

// bits in one address or data byte.
`define I2C_BYTE_BITS 8

// the tick counter has to hold I2C_PRESCALER * I2C_BYTE_BITS.
`define I2C_CNT_W 5

// width of the byte count that comes with a write command.
`define I2C_LEN_W 8

`endif

/* source/i2c_cu_pkg.sv */
`default_nettype none

`include "i2c_cu_settings.svh"

package i2c_cu_pkg;

    // phases of one command, encoded as in the older controller.
    typedef enum logic [3:0] {
        ph_idle      = 4'd0,
        ph_start     = 4'd1,
        ph_dev_addr  = 4'd2,
        ph_dev_ack   = 4'd3,
        ph_reg_addr  = 4'd4,
        ph_reg_ack   = 4'd5,
        ph_rep_start = 4'd6,
        ph_read      = 4'd7,
        ph_read_ack  = 4'd8,
        ph_write     = 4'd9,
        ph_write_ack = 4'd10,
        ph_stop      = 4'd11,
        ph_error     = 4'd12
    } phase_e;

    // clock ticks inside one slot.
    typedef logic [`I2C_CNT_W-1:0] tick_t;

    // number of data bytes in a write command.
    typedef logic [`I2C_LEN_W-1:0] len_t;

endpackage

`default_nettype wire

/* source/slot_timer.sv */
`default_nettype none

`include "i2c_cu_settings.svh"

module slot_timer
    import i2c_cu_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire phase_e phase_i,
    output tick_t       tick_o,
    output logic        byte_end_o,
    output logic        pair_end_o
);

    localparam tick_t BYTE_LAST = tick_t'(`I2C_PRESCALER * `I2C_BYTE_BITS);

    logic  byte_phase;
    logic  pair_phase;
    tick_t tick_next;

    // address and data slots run for a full byte, rep_start and stop for two ticks.
    assign byte_phase = (phase_i == ph_dev_addr) || (phase_i == ph_reg_addr)
                     || (phase_i == ph_write) || (phase_i == ph_read);
    assign pair_phase = (phase_i == ph_rep_start) || (phase_i == ph_stop);

    assign byte_end_o = (tick_o == BYTE_LAST);
    assign pair_end_o = (tick_o == tick_t'(1));

    // the count restarts at zero whenever a slot ends or the phase does not count.
    always_comb begin
        if (byte_phase && !byte_end_o) begin
            tick_next = tick_o + tick_t'(1);
        end else if (pair_phase && !pair_end_o) begin
            tick_next = tick_o + tick_t'(1);
        end else begin
            tick_next = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            tick_o <= '0;
        end else begin
            tick_o <= tick_next;
        end
    end

    a_tick_in_slot: assert property (
        @(posedge clk) disable iff (!rst)
        tick_o <= BYTE_LAST
    ) else $error("slot_timer: tick count %0d passed the byte slot end", tick_o);

endmodule

`default_nettype wire

/* source/xfer_budget.sv */
`default_nettype none

module xfer_budget
    import i2c_cu_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire phase_e phase_i,
    input  wire logic   valid_cmd_i,
    input  wire logic   rw_i,
    input  wire len_t   data_len_i,
    output logic        is_read_o,
    output logic        last_byte_o
);

    len_t bytes_left;
    logic accept;

    // a command is taken only while the controller sits in idle.
    assign accept = (phase_i == ph_idle) && valid_cmd_i;

    assign last_byte_o = (bytes_left == len_t'(1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            is_read_o  <= 1'b0;
            bytes_left <= '0;
        end else if (accept) begin
            is_read_o  <= rw_i;
            bytes_left <= data_len_i;
        end else if (phase_i == ph_write_ack) begin
            // one byte is done each time its ACK slot comes by.
            bytes_left <= bytes_left - len_t'(1);
        end
    end

    a_write_len_nonzero: assert property (
        @(posedge clk) disable iff (!rst)
        accept && !rw_i |-> data_len_i != '0
    ) else $error("xfer_budget: write command accepted with zero length");

    // the count never runs out before the last write ACK.
    a_budget_left: assert property (
        @(posedge clk) disable iff (!rst)
        phase_i == ph_write |-> bytes_left != '0
    ) else $error("xfer_budget: write byte sent with no budget left");

endmodule

`default_nettype wire

/* source/i2c_phase_seq.sv */
`default_nettype none

module i2c_phase_seq
    import i2c_cu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  valid_cmd_i,
    input  wire logic  ack_i,
    input  wire tick_t tick_i,
    input  wire logic  byte_end_i,
    input  wire logic  pair_end_i,
    input  wire logic  is_read_i,
    input  wire logic  last_byte_i,
    output phase_e     phase_o,
    output logic       start_bit_o,
    output logic       stop_bit_o,
    output logic       send_addr_o,
    output logic       send_data_o,
    output logic       read_ack_o,
    output logic       repeated_start_o,
    output logic       send_ack_o,
    output logic       read_data_o,
    output logic       sda_t_o,
    output logic       ack_o
);

    phase_e phase_next;
    logic   addr_pass;
    logic   first_tick;

    assign first_tick = (tick_i == '0);

    // addr_pass marks that the register address is out, so the second
    // device address of a read leads into the data byte.
    always_ff @(posedge clk) begin
        if (!rst) begin
            phase_o   <= ph_idle;
            addr_pass <= 1'b0;
        end else begin
            phase_o <= phase_next;
            if (phase_o == ph_idle) begin
                addr_pass <= 1'b0;
            end else if ((phase_o == ph_reg_addr) && byte_end_i) begin
                addr_pass <= 1'b1;
            end
        end
    end

    always_comb begin
        phase_next = phase_o;
        case (phase_o)
            ph_idle: begin
                if (valid_cmd_i) begin
                    phase_next = ph_start;
                end
            end
            ph_start: begin
                phase_next = ph_dev_addr;
            end
            ph_dev_addr: begin
                if (byte_end_i) begin
                    phase_next = ph_dev_ack;
                end
            end
            ph_dev_ack: begin
                if (ack_i) begin
                    phase_next = ph_error;
                end else if (addr_pass) begin
                    phase_next = ph_read;
                end else begin
                    phase_next = ph_reg_addr;
                end
            end
            ph_reg_addr: begin
                if (byte_end_i) begin
                    phase_next = ph_reg_ack;
                end
            end
            ph_reg_ack: begin
                if (ack_i) begin
                    phase_next = ph_error;
                end else if (is_read_i) begin
                    phase_next = ph_rep_start;
                end else begin
                    phase_next = ph_write;
                end
            end
            ph_rep_start: begin
                if (pair_end_i) begin
                    phase_next = ph_dev_addr;
                end
            end
            ph_read: begin
                if (byte_end_i) begin
                    phase_next = ph_read_ack;
                end
            end
            ph_read_ack: begin
                phase_next = ph_stop;
            end
            ph_write: begin
                if (byte_end_i) begin
                    phase_next = ph_write_ack;
                end
            end
            ph_write_ack: begin
                if (ack_i) begin
                    phase_next = ph_error;
                end else if (last_byte_i) begin
                    phase_next = ph_stop;
                end else begin
                    phase_next = ph_write;
                end
            end
            ph_stop: begin
                if (pair_end_i) begin
                    phase_next = ph_idle;
                end
            end
            default: begin
                phase_next = ph_idle;
            end
        endcase
    end

    // strobes depend only on the registered phase and tick.
    always_comb begin
        start_bit_o      = 1'b0;
        stop_bit_o       = 1'b0;
        send_addr_o      = 1'b0;
        send_data_o      = 1'b0;
        read_ack_o       = 1'b0;
        repeated_start_o = 1'b0;
        send_ack_o       = 1'b0;
        read_data_o      = 1'b0;
        sda_t_o          = 1'b0;
        ack_o            = 1'b1;
        case (phase_o)
            ph_start: begin
                start_bit_o = 1'b1;
            end
            ph_dev_addr, ph_reg_addr: begin
                send_addr_o = !byte_end_i;
                read_ack_o  = byte_end_i;
                sda_t_o     = (phase_o == ph_reg_addr) && first_tick;
            end
            ph_write: begin
                send_data_o = !byte_end_i;
                read_ack_o  = byte_end_i;
                sda_t_o     = first_tick;
            end
            ph_dev_ack, ph_reg_ack, ph_write_ack: begin
                sda_t_o = 1'b1;
            end
            ph_rep_start: begin
                repeated_start_o = first_tick;
                sda_t_o          = first_tick;
                start_bit_o      = pair_end_i;
            end
            ph_read: begin
                sda_t_o     = 1'b1;
                read_data_o = !byte_end_i;
                send_ack_o  = byte_end_i;
                ack_o       = !byte_end_i;
            end
            ph_read_ack: begin
                ack_o = 1'b0;
            end
            ph_stop: begin
                sda_t_o    = first_tick;
                stop_bit_o = pair_end_i;
            end
            default: begin
                ack_o = 1'b1;
            end
        endcase
    end

    a_start_stop_excl: assert property (
        @(posedge clk) disable iff (!rst)
        !(start_bit_o && stop_bit_o)
    ) else $error("i2c_phase_seq: start and stop strobes high together");

endmodule

`default_nettype wire

/* source/i2c_master_cu.sv */
`default_nettype none

module i2c_master_cu
    import i2c_cu_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic valid_cmd_i,
    input  wire logic rw_i,
    input  wire logic ack_i,
    input  wire len_t data_len_i,
    output logic      start_bit_o,
    output logic      stop_bit_o,
    output logic      send_addr_o,
    output logic      send_data_o,
    output logic      read_ack_o,
    output logic      repeated_start_o,
    output logic      send_ack_o,
    output logic      read_data_o,
    output logic      sda_t_o,
    output logic      ack_o
);

    phase_e phase;
    tick_t  tick;
    logic   byte_end;
    logic   pair_end;
    logic   is_read;
    logic   last_byte;

    i2c_phase_seq u_i2c_phase_seq (
        .clk              (clk),
        .rst              (rst),
        .valid_cmd_i      (valid_cmd_i),
        .ack_i            (ack_i),
        .tick_i           (tick),
        .byte_end_i       (byte_end),
        .pair_end_i       (pair_end),
        .is_read_i        (is_read),
        .last_byte_i      (last_byte),
        .phase_o          (phase),
        .start_bit_o      (start_bit_o),
        .stop_bit_o       (stop_bit_o),
        .send_addr_o      (send_addr_o),
        .send_data_o      (send_data_o),
        .read_ack_o       (read_ack_o),
        .repeated_start_o (repeated_start_o),
        .send_ack_o       (send_ack_o),
        .read_data_o      (read_data_o),
        .sda_t_o          (sda_t_o),
        .ack_o            (ack_o)
    );

    slot_timer u_slot_timer (
        .clk        (clk),
        .rst        (rst),
        .phase_i    (phase),
        .tick_o     (tick),
        .byte_end_o (byte_end),
        .pair_end_o (pair_end)
    );

    xfer_budget u_xfer_budget (
        .clk         (clk),
        .rst         (rst),
        .phase_i     (phase),
        .valid_cmd_i (valid_cmd_i),
        .rw_i        (rw_i),
        .data_len_i  (data_len_i),
        .is_read_o   (is_read),
        .last_byte_o (last_byte)
    );

endmodule

`default_nettype wire

/* test/tb_i2c_master_cu.sv */
`default_nettype none

`include "i2c_cu_settings.svh"

module tb_i2c_master_cu
    import i2c_cu_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_CMDS = 40;
    localparam int MAX_GAP = 7;
    localparam int SLOT_TICKS = `I2C_PRESCALER * `I2C_BYTE_BITS;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + NUM_CMDS * (39 + 18 * 4 + MAX_GAP + 1) + 200;

    logic clk = 1'b0;
    logic rst;
    logic valid_cmd_i;
    logic rw_i;
    logic ack_i;
    len_t data_len_i;
    logic start_bit_o;
    logic stop_bit_o;
    logic send_addr_o;
    logic send_data_o;
    logic read_ack_o;
    logic repeated_start_o;
    logic send_ack_o;
    logic read_data_o;
    logic sda_t_o;
    logic ack_o;

    string out_names [10] = '{"start_bit_o", "stop_bit_o", "send_addr_o", "send_data_o",
        "read_ack_o", "repeated_start_o", "send_ack_o", "read_data_o", "sda_t_o", "ack_o"};

    logic [15:0] lfsr;
    phase_e m_phase = ph_idle;
    int m_cnt;
    int m_left;
    logic m_read;
    logic m_pass;
    logic aborted;
    logic end_pending;
    int gap_left;
    int gap_exp;
    int idle_run;
    int cycle_no;
    int cmds_started;
    int done_cmds;
    int error_count;
    int cmd_len;
    int cmd_cycles;
    int n_start, n_stop, n_send_data, n_read_ack, n_rep_start;
    int n_read_data, n_send_ack, n_ack_low, n_quiet;

    i2c_master_cu u_i2c_master_cu (
        .clk              (clk),
        .rst              (rst),
        .valid_cmd_i      (valid_cmd_i),
        .rw_i             (rw_i),
        .ack_i            (ack_i),
        .data_len_i       (data_len_i),
        .start_bit_o      (start_bit_o),
        .stop_bit_o       (stop_bit_o),
        .send_addr_o      (send_addr_o),
        .send_data_o      (send_data_o),
        .read_ack_o       (read_ack_o),
        .repeated_start_o (repeated_start_o),
        .send_ack_o       (send_ack_o),
        .read_data_o      (read_data_o),
        .sda_t_o          (sda_t_o),
        .ack_o            (ack_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    task automatic draw_bits(input int width, output int value);
        value = 0;
        for (int i = 0; i < width; i++) begin
            lfsr = lfsr_step(lfsr);
            value = (value << 1) | (lfsr[0] ? 1 : 0);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // output order follows out_names, start_bit_o in the top bit.
    function automatic logic [9:0] expected_outputs(input phase_e ph, input int cnt);
        logic st, sp, sa, sd, ra, rs, sk, rd, sda, ack;
        logic slot_end;
        {st, sp, sa, sd, ra, rs, sk, rd, sda} = '0;
        ack = 1'b1;
        slot_end = (cnt == SLOT_TICKS);
        case (ph)
            ph_start: st = 1'b1;
            ph_dev_addr, ph_reg_addr: begin
                sa = !slot_end;
                ra = slot_end;
                sda = (ph == ph_reg_addr) && (cnt == 0);
            end
            ph_write: begin
                sd = !slot_end;
                ra = slot_end;
                sda = (cnt == 0);
            end
            ph_dev_ack, ph_reg_ack, ph_write_ack: sda = 1'b1;
            ph_rep_start: begin
                rs = (cnt == 0);
                sda = (cnt == 0);
                st = (cnt == 1);
            end
            ph_read: begin
                sda = 1'b1;
                rd = !slot_end;
                sk = slot_end;
                ack = !slot_end;
            end
            ph_read_ack: ack = 1'b0;
            ph_stop: begin
                sda = (cnt == 0);
                sp = (cnt == 1);
            end
            default: ack = 1'b1;
        endcase
        return {st, sp, sa, sd, ra, rs, sk, rd, sda, ack};
    endfunction

    task automatic begin_command();
        if (cmds_started > 0) begin
            check_value($sformatf("cmd %0d idle cycles before start", cmds_started),
                        gap_exp + 1, idle_run);
        end
        m_read = rw_i;
        m_left = int'(data_len_i);
        cmd_len = int'(data_len_i);
        m_pass = 1'b0;
        aborted = 1'b0;
        {n_start, n_stop, n_send_data, n_read_ack, n_rep_start} = '0;
        {n_read_data, n_send_ack, n_ack_low, n_quiet, cmd_cycles} = '0;
        cmds_started++;
        draw_bits(3, gap_left);
        gap_exp = gap_left;
    endtask

    // one clock of the reference model, using the inputs the DUT samples at this edge.
    task automatic model_step();
        phase_e next;
        next = m_phase;
        case (m_phase)
            ph_idle: begin
                if (valid_cmd_i) begin
                    next = ph_start;
                    begin_command();
                end
            end
            ph_start: next = ph_dev_addr;
            ph_dev_addr: begin
                if (m_cnt == SLOT_TICKS) begin
                    next = ph_dev_ack;
                end
            end
            ph_dev_ack: begin
                if (ack_i) begin
                    next = ph_error;
                end else begin
                    next = m_pass ? ph_read : ph_reg_addr;
                end
            end
            ph_reg_addr: begin
                if (m_cnt == SLOT_TICKS) begin
                    next = ph_reg_ack;
                    m_pass = 1'b1;
                end
            end
            ph_reg_ack: begin
                if (ack_i) begin
                    next = ph_error;
                end else begin
                    next = m_read ? ph_rep_start : ph_write;
                end
            end
            ph_rep_start: begin
                if (m_cnt == 1) begin
                    next = ph_dev_addr;
                end
            end
            ph_read: begin
                if (m_cnt == SLOT_TICKS) begin
                    next = ph_read_ack;
                end
            end
            ph_read_ack: next = ph_stop;
            ph_write: begin
                if (m_cnt == SLOT_TICKS) begin
                    next = ph_write_ack;
                end
            end
            ph_write_ack: begin
                if (ack_i) begin
                    next = ph_error;
                end else begin
                    next = (m_left == 1) ? ph_stop : ph_write;
                end
                m_left--;
            end
            ph_stop: begin
                if (m_cnt == 1) begin
                    next = ph_idle;
                end
            end
            default: next = ph_idle;
        endcase
        if (next == ph_error) begin
            aborted = 1'b1;
        end
        if ((next == ph_idle) && (m_phase != ph_idle)) begin
            end_pending = 1'b1;
            idle_run = 0;
        end
        m_cnt = (next == m_phase) ? m_cnt + 1 : 0;
        m_phase = next;
    endtask

    // new inputs for the next edge; busy cycles get random values that must be ignored.
    task automatic drive_inputs();
        int v;
        draw_bits(1, v);
        rw_i <= v[0];
        draw_bits(8, v);
        data_len_i <= len_t'(v);
        draw_bits(1, v);
        ack_i <= v[0];
        if (m_phase == ph_idle) begin
            if ((gap_left == 0) && (cmds_started < NUM_CMDS)) begin
                draw_bits(1, v);
                rw_i <= v[0];
                draw_bits(2, v);
                data_len_i <= len_t'(v + 1);
                valid_cmd_i <= 1'b1;
            end else begin
                valid_cmd_i <= 1'b0;
                if (gap_left > 0) begin
                    gap_left--;
                end
            end
        end else begin
            draw_bits(1, v);
            valid_cmd_i <= v[0];
            if (m_phase inside {ph_dev_ack, ph_reg_ack, ph_write_ack}) begin
                draw_bits(3, v);
                ack_i <= (v == 7);
            end
        end
    endtask

    task automatic compare_outputs();
        logic [9:0] exp_vec;
        logic [9:0] act_vec;
        exp_vec = expected_outputs(m_phase, m_cnt);
        act_vec = {start_bit_o, stop_bit_o, send_addr_o, send_data_o, read_ack_o,
                   repeated_start_o, send_ack_o, read_data_o, sda_t_o, ack_o};
        for (int i = 0; i < 10; i++) begin
            check_value($sformatf("cycle %0d %s", cycle_no, out_names[i]),
                        32'(exp_vec[9 - i]), 32'(act_vec[9 - i]));
        end
        cycle_no++;
    endtask

    task automatic finish_command();
        string tag;
        tag = $sformatf("cmd %0d", done_cmds);
        if (aborted) begin
            check_value({tag, " nack stop_bit_o pulses"}, 0, n_stop);
            check_value({tag, " nack cycles with idle outputs"}, 1, n_quiet);
        end else if (m_read) begin
            check_value({tag, " read start_bit_o pulses"}, 2, n_start);
            check_value({tag, " read repeated_start_o cycles"}, 1, n_rep_start);
            check_value({tag, " read read_data_o cycles"}, SLOT_TICKS, n_read_data);
            check_value({tag, " read send_ack_o cycles"}, 1, n_send_ack);
            check_value({tag, " read ack_o low cycles"}, 2, n_ack_low);
            check_value({tag, " read stop_bit_o pulses"}, 1, n_stop);
            check_value({tag, " read length"}, 77, cmd_cycles);
        end else begin
            check_value({tag, " write start_bit_o pulses"}, 1, n_start);
            check_value({tag, " write stop_bit_o pulses"}, 1, n_stop);
            check_value({tag, " write send_data_o cycles"}, SLOT_TICKS * cmd_len, n_send_data);
            check_value({tag, " write read_ack_o pulses"}, cmd_len + 2, n_read_ack);
            check_value({tag, " write length"}, 39 + 18 * cmd_len, cmd_cycles);
        end
        done_cmds++;
    endtask

    task automatic track_command();
        logic [9:0] outs;
        outs = {start_bit_o, stop_bit_o, send_addr_o, send_data_o, read_ack_o,
                repeated_start_o, send_ack_o, read_data_o, sda_t_o, ack_o};
        if (end_pending) begin
            end_pending = 1'b0;
            finish_command();
        end
        if (m_phase == ph_idle) begin
            idle_run++;
        end else begin
            cmd_cycles++;
            n_start = n_start + (start_bit_o ? 1 : 0);
            n_stop = n_stop + (stop_bit_o ? 1 : 0);
            n_send_data = n_send_data + (send_data_o ? 1 : 0);
            n_read_ack = n_read_ack + (read_ack_o ? 1 : 0);
            n_rep_start = n_rep_start + (repeated_start_o ? 1 : 0);
            n_read_data = n_read_data + (read_data_o ? 1 : 0);
            n_send_ack = n_send_ack + (send_ack_o ? 1 : 0);
            n_ack_low = n_ack_low + (ack_o ? 0 : 1);
            // only the error cycle of an aborted command shows the idle output values.
            n_quiet = n_quiet + ((outs === 10'b0000000001) ? 1 : 0);
        end
    endtask

    initial begin
        rst = 1'b0;
        valid_cmd_i = 1'b0;
        rw_i = 1'b0;
        ack_i = 1'b0;
        data_len_i = '0;
        lfsr = 16'd14;
        {m_cnt, m_left, idle_run, cycle_no, cmds_started, done_cmds, error_count} = '0;
        {m_read, m_pass, aborted, end_pending} = '0;
        draw_bits(3, gap_left);
        gap_exp = gap_left;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            compare_outputs();
        end
        @(posedge clk);
        rst <= 1'b1;
        drive_inputs();
        @(negedge clk);
        compare_outputs();
        while (done_cmds < NUM_CMDS) begin
            @(posedge clk);
            model_step();
            drive_inputs();
            @(negedge clk);
            compare_outputs();
            track_command();
        end
        if (error_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "%0d checks failed", error_count);
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("the run hung: %0d of %0d commands finished in time", done_cmds, NUM_CMDS);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
source/i2c_cu_pkg.sv
source/slot_timer.sv
source/xfer_budget.sv
source/i2c_phase_seq.sv
source/i2c_master_cu.sv
test/tb_i2c_master_cu.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_i2c_master_cu
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
